// ==== hw/riscv_ctrl_pkg.sv ====
package riscv_ctrl_pkg;

    // Fixed ISA widths
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Base opcodes used by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ALU opcodes keep the datapath encoding, gaps are the retired MUL, DIV and NOT
    typedef enum logic [7:0] {
        ALU_ADD  = 8'd0,
        ALU_ADDI = 8'd1,
        ALU_SUB  = 8'd2,
        ALU_SLL  = 8'd5,
        ALU_SRL  = 8'd6,
        ALU_AND  = 8'd7,
        ALU_OR   = 8'd8,
        ALU_XOR  = 8'd10,
        ALU_LUI  = 8'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        OP2_RS2  = 2'd0,
        OP2_UIMM = 2'd1,
        OP2_IMM  = 2'd2
    } op2_sel_e;

    typedef enum logic [1:0] {
        REG_SRC_NONE = 2'd0,
        REG_SRC_MEM  = 2'd1,
        REG_SRC_ALU  = 2'd2
    } reg_src_e;

    // PC unit picks the branch condition from this
    typedef enum logic [1:0] {
        PC_SRC_EQ = 2'd0,
        PC_SRC_GE = 2'd3
    } pc_src_e;

    typedef enum logic [2:0] {
        CLS_ILLEGAL = 3'd0,
        CLS_ALU     = 3'd1,
        CLS_LOAD    = 3'd2,
        CLS_STORE   = 3'd3,
        CLS_BRANCH  = 3'd4
    } instr_class_e;

    typedef enum logic [3:0] {
        ST_FETCH      = 4'd0,
        ST_IR_LOAD    = 4'd1,
        ST_ALU_EXEC   = 4'd2,
        ST_ALU_WB     = 4'd3,
        ST_LD_REQ     = 4'd4,
        ST_LD_WB      = 4'd5,
        ST_SD_BUS     = 4'd6,
        ST_SD_IDLE    = 4'd7,
        ST_SD_WRITE   = 4'd8,
        ST_SD_DONE    = 4'd9,
        ST_BR_CMP     = 4'd10,
        ST_BR_RESOLVE = 4'd11
    } ctrl_state_e;

    // Result of instruction classification
    typedef struct packed {
        instr_class_e cls;
        alu_op_e      alu_op;
        op2_sel_e     op2_sel;
        pc_src_e      pc_src;
    } decoded_t;

    typedef struct packed {
        logic cs;
        logic we;
        logic oe;
    } ram_ctrl_t;

    typedef struct packed {
        logic    en;
        pc_src_e src;
        logic    sign;
    } pc_ctrl_t;

    typedef struct packed {
        logic     en;
        logic     we;
        reg_src_e src;
    } reg_ctrl_t;

    typedef struct packed {
        logic     en;
        alu_op_e  op;
        op2_sel_e op2_sel;
    } alu_ctrl_t;

    // Full strobe set toward the datapath
    typedef struct packed {
        ram_ctrl_t ram;
        pc_ctrl_t  pc;
        logic      ir_en;
        reg_ctrl_t rf;
        alu_ctrl_t alu;
    } ctrl_word_t;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  riscv_ctrl_pkg::instr_t   instr,
    output riscv_ctrl_pkg::decoded_t decoded
);
    import riscv_ctrl_pkg::*;

    // funct3 codes
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_DOUBLE  = 3'b011;
    localparam funct3_t F3_XOR_DIV = 3'b100;
    localparam funct3_t F3_SRL     = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BGE     = 3'b101;

    // funct7 codes of the R-type group
    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign is_op  = (opcode == OPC_OP);

    // Same priority as the original if-chain; register fields never looked at
    always_comb begin
        decoded.cls     = CLS_ILLEGAL;
        decoded.alu_op  = ALU_ADD;
        decoded.op2_sel = OP2_RS2;
        decoded.pc_src  = PC_SRC_EQ;

        if (opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB) begin
            decoded.cls     = CLS_ALU;
            decoded.alu_op  = ALU_ADDI;
            decoded.op2_sel = OP2_IMM;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_ADD_SUB) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_ADD;
        end else if (is_op && funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_SUB;
        end else if (is_op && funct7 == F7_MULDIV) begin
            // MUL and DIV no longer supported
            decoded.cls = CLS_ILLEGAL;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_SLL) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_SLL;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_SRL) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_SRL;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_OR) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_OR;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_AND) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_AND;
        end else if (is_op && funct7 == F7_BASE && funct3 == F3_XOR_DIV) begin
            decoded.cls    = CLS_ALU;
            decoded.alu_op = ALU_XOR;
        end else if (opcode == OPC_LOAD && funct3 == F3_DOUBLE) begin
            decoded.cls = CLS_LOAD;
        end else if (opcode == OPC_STORE && funct3 == F3_DOUBLE) begin
            decoded.cls = CLS_STORE;
        end else if (opcode == OPC_BRANCH && funct3 == F3_BEQ) begin
            decoded.cls    = CLS_BRANCH;
            decoded.alu_op = ALU_SUB;
            decoded.pc_src = PC_SRC_EQ;
        end else if (opcode == OPC_BRANCH && funct3 == F3_BGE) begin
            decoded.cls    = CLS_BRANCH;
            decoded.alu_op = ALU_SUB;
            decoded.pc_src = PC_SRC_GE;
        end else if (opcode == OPC_LUI) begin
            decoded.cls     = CLS_ALU;
            decoded.alu_op  = ALU_LUI;
            decoded.op2_sel = OP2_UIMM;
        end
    end

endmodule

// ==== hw/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  riscv_ctrl_pkg::decoded_t      decoded,
    output riscv_ctrl_pkg::ctrl_state_e   state,
    output riscv_ctrl_pkg::decoded_t      decoded_q
);
    import riscv_ctrl_pkg::*;

    // Cleared decode reads as an illegal instruction
    localparam decoded_t DECODED_CLR = '{
        cls:     CLS_ILLEGAL,
        alu_op:  ALU_ADD,
        op2_sel: OP2_RS2,
        pc_src:  PC_SRC_EQ
    };

    ctrl_state_e state_nxt;

    always_comb begin
        state_nxt = ST_FETCH;
        case (state)
            ST_FETCH: begin
                state_nxt = ST_IR_LOAD;
            end
            ST_IR_LOAD: begin
                // Dispatch on class only, opcode bits stay in the decoder
                case (decoded.cls)
                    CLS_ALU:    state_nxt = ST_ALU_EXEC;
                    CLS_LOAD:   state_nxt = ST_LD_REQ;
                    CLS_STORE:  state_nxt = ST_SD_BUS;
                    CLS_BRANCH: state_nxt = ST_BR_CMP;
                    default:    state_nxt = ST_FETCH;
                endcase
            end
            ST_ALU_EXEC:   state_nxt = ST_ALU_WB;
            ST_ALU_WB:     state_nxt = ST_FETCH;
            ST_LD_REQ:     state_nxt = ST_LD_WB;
            ST_LD_WB:      state_nxt = ST_FETCH;
            // Store walks the chip-select sequence
            ST_SD_BUS:     state_nxt = ST_SD_IDLE;
            ST_SD_IDLE:    state_nxt = ST_SD_WRITE;
            ST_SD_WRITE:   state_nxt = ST_SD_DONE;
            ST_SD_DONE:    state_nxt = ST_FETCH;
            ST_BR_CMP:     state_nxt = ST_BR_RESOLVE;
            ST_BR_RESOLVE: state_nxt = ST_FETCH;
            default:       state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // Decode is held from the end of IR_LOAD through the execute states
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded_q <= DECODED_CLR;
        end else if (state == ST_IR_LOAD) begin
            decoded_q <= decoded;
        end
    end

endmodule

// ==== hw/ctrl_word_gen.sv ====
`timescale 1ns/1ps

module ctrl_word_gen (
    input  logic                        arst_n,
    input  riscv_ctrl_pkg::ctrl_state_e state,
    input  riscv_ctrl_pkg::decoded_t    decoded_q,
    output riscv_ctrl_pkg::ctrl_word_t  ctrl
);
    import riscv_ctrl_pkg::*;

    ctrl_word_t word;

    // Each state sets only what it needs, everything else stays zero
    always_comb begin
        word = '0;
        case (state)
            ST_FETCH: begin
                word.ram.cs = 1'b1;
                word.ram.oe = 1'b1;
                word.pc.en  = 1'b1;
            end
            ST_IR_LOAD: begin
                word.ir_en = 1'b1;
            end
            ST_ALU_EXEC: begin
                word.alu.en      = 1'b1;
                word.alu.op      = decoded_q.alu_op;
                word.alu.op2_sel = decoded_q.op2_sel;
            end
            ST_ALU_WB: begin
                word.rf.en  = 1'b1;
                word.rf.we  = 1'b1;
                word.rf.src = REG_SRC_ALU;
            end
            ST_LD_REQ: begin
                word.ram.cs = 1'b1;
                word.ram.oe = 1'b1;
            end
            ST_LD_WB: begin
                word.rf.en  = 1'b1;
                word.rf.we  = 1'b1;
                word.rf.src = REG_SRC_MEM;
            end
            // Store: first cs pulse makes the RAM release the bus
            ST_SD_BUS: begin
                word.ram.we = 1'b1;
                word.ram.cs = 1'b1;
            end
            ST_SD_IDLE: begin
                word.ram.we = 1'b1;
            end
            // Second cs pulse does the actual write
            ST_SD_WRITE: begin
                word.ram.we = 1'b1;
                word.ram.cs = 1'b1;
            end
            ST_SD_DONE: begin
                word.ram.we = 1'b1;
            end
            ST_BR_CMP: begin
                // Both branches compare by subtraction
                word.alu.en      = 1'b1;
                word.alu.op      = ALU_SUB;
                word.alu.op2_sel = OP2_RS2;
            end
            ST_BR_RESOLVE: begin
                word.pc.en   = 1'b1;
                word.pc.sign = 1'b1;
                word.pc.src  = decoded_q.pc_src;
            end
            default: begin
                word = '0;
            end
        endcase
    end

    // Hold all strobes low while in reset
    assign ctrl = arst_n ? word : '0;

endmodule

// ==== hw/riscv_ctrl.sv ====
`timescale 1ns/1ps

module riscv_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  riscv_ctrl_pkg::instr_t     instr,
    output riscv_ctrl_pkg::ctrl_word_t ctrl
);
    import riscv_ctrl_pkg::*;

    decoded_t    decoded;
    decoded_t    decoded_q;
    ctrl_state_e state;

    instr_decoder i_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    ctrl_sequencer i_sequencer (
        .clk       (clk),
        .arst_n    (arst_n),
        .decoded   (decoded),
        .state     (state),
        .decoded_q (decoded_q)
    );

    ctrl_word_gen i_word_gen (
        .arst_n    (arst_n),
        .state     (state),
        .decoded_q (decoded_q),
        .ctrl      (ctrl)
    );

endmodule

// ==== verif/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Fetch drives the RAM read and the PC step
function automatic ctrl_word_t fetch_word();
    ctrl_word_t w;
    w        = '0;
    w.ram.cs = 1'b1;
    w.ram.oe = 1'b1;
    w.pc.en  = 1'b1;
    return w;
endfunction

// Cycles from one fetch to the next
function automatic int path_length(input instr_class_e cls);
    case (cls)
        CLS_ALU:    return 4;
        CLS_LOAD:   return 4;
        CLS_STORE:  return 6;
        CLS_BRANCH: return 4;
        default:    return 2;
    endcase
endfunction

// Expected control word at a given step of an instruction's path
function automatic ctrl_word_t expected_word(input instr_class_e cls, input alu_op_e op,
                                             input instr_t word, input int step);
    ctrl_word_t w;
    w = '0;
    if (step == 0) begin
        w = fetch_word();
    end else if (step == 1) begin
        w.ir_en = 1'b1;
    end else begin
        case (cls)
            CLS_ALU: begin
                if (step == 2) begin
                    w.alu.en      = 1'b1;
                    w.alu.op      = op;
                    w.alu.op2_sel = (op == ALU_ADDI) ? OP2_IMM :
                                    (op == ALU_LUI)  ? OP2_UIMM : OP2_RS2;
                end else begin
                    w.rf.en  = 1'b1;
                    w.rf.we  = 1'b1;
                    w.rf.src = REG_SRC_ALU;
                end
            end
            CLS_LOAD: begin
                if (step == 2) begin
                    w.ram.cs = 1'b1;
                    w.ram.oe = 1'b1;
                end else begin
                    w.rf.en  = 1'b1;
                    w.rf.we  = 1'b1;
                    w.rf.src = REG_SRC_MEM;
                end
            end
            CLS_STORE: begin
                // we stays high, cs pulses on steps 2 and 4
                w.ram.we = 1'b1;
                w.ram.cs = (step == 2 || step == 4);
            end
            CLS_BRANCH: begin
                if (step == 2) begin
                    w.alu.en      = 1'b1;
                    w.alu.op      = ALU_SUB;
                    w.alu.op2_sel = OP2_RS2;
                end else begin
                    w.pc.en   = 1'b1;
                    w.pc.sign = 1'b1;
                    w.pc.src  = (word[14:12] == 3'b101) ? PC_SRC_GE : PC_SRC_EQ;
                end
            end
            default: begin
                w = '0;
            end
        endcase
    end
    return w;
endfunction

task automatic check_ctrl(input ctrl_word_t got, input ctrl_word_t exp, input string what);
    if (got !== exp) begin
        $display("FAIL %0d ns: test %0d %s: ctrl %h, expected %h", $time, cur_test, what,
                 got, exp);
        test_errors++;
    end
endtask

task automatic check_alu_op(input alu_op_e got, input alu_op_e exp, input string what);
    if (got !== exp) begin
        $display("FAIL %0d ns: test %0d %s: alu_op %0d, expected %0d", $time, cur_test,
                 what, got, exp);
        test_errors++;
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("FAIL %0d ns: test %0d %s: %0d cycles, expected %0d", $time, cur_test,
                 what, got, exp);
        test_errors++;
    end
endtask

`endif

// ==== verif/tb_riscv_ctrl.sv ====
`timescale 1ns/1ps

module tb_riscv_ctrl;
    import riscv_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int TRACE_WORDS  = 256;
    localparam int MAX_PATH     = 8;

    logic       clk;
    logic       arst_n;
    instr_t     instr;
    ctrl_word_t ctrl;

    // Four words per record: instr, test number, class, alu_op
    logic [31:0] trace_mem [0:TRACE_WORDS-1];
    int          num_tests;
    bit          trace_loaded;
    int          cur_test;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    logic [31:0] lcg_state;

    `include "tb_checks.svh"

    riscv_ctrl i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // R-type words get random rd, rs1 and rs2
    function automatic instr_t fill_reg_fields(input instr_t word);
        logic [31:0] r;
        instr_t      w;
        w = word;
        if (word[6:0] == OPC_OP) begin
            r        = lcg_next();
            w[11:7]  = r[14:10];
            w[19:15] = r[20:16];
            w[24:20] = r[26:22];
        end
        return w;
    endfunction

    // Called on a falling edge once the decode of the current word is taken
    task automatic drive_next(input int t);
        if (t + 1 < num_tests) begin
            instr = fill_reg_fields(trace_mem[(t + 1) * 4]);
        end else begin
            instr = '0;
        end
    endtask

    task automatic finish_test(input string label);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d %s: pass", cur_test, label);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d mismatches", cur_test, label, test_errors);
        end
    endtask

    initial begin
        ctrl_word_t   sample;
        instr_t       cur_instr;
        instr_class_e exp_cls;
        alu_op_e      exp_op;
        int           exp_len;
        int           steps;
        bit           back_to_fetch;
        bit           next_driven;

        arst_n       = 1'b0;
        instr        = '0;
        lcg_state    = 32'd97;
        pass_count   = 0;
        fail_count   = 0;
        trace_loaded = 1'b0;
        $readmemh("verif/ctrl_trace.txt", trace_mem);
        num_tests = 0;
        while (num_tests * 4 < TRACE_WORDS && !$isunknown(trace_mem[num_tests * 4])) begin
            num_tests++;
        end
        trace_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("Trace file verif/ctrl_trace.txt holds no records");
            fail_count++;
        end else begin
            instr = fill_reg_fields(trace_mem[0]);
        end

        // Reset behavior, then the first fetch after release
        cur_test    = 0;
        test_errors = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_ctrl(ctrl, '0, "during reset");
        end
        arst_n = 1'b1;
        #(CLK_PERIOD / 4);
        sample = ctrl;
        finish_test("reset");

        for (int t = 0; t < num_tests; t++) begin
            cur_test    = int'(trace_mem[t * 4 + 1]);
            exp_cls     = instr_class_e'(trace_mem[t * 4 + 2][2:0]);
            exp_op      = alu_op_e'(trace_mem[t * 4 + 3][7:0]);
            cur_instr   = instr;
            exp_len     = path_length(exp_cls);
            test_errors = 0;
            check_ctrl(sample, expected_word(exp_cls, exp_op, cur_instr, 0), "step 0");
            steps         = 1;
            back_to_fetch = 1'b0;
            next_driven   = 1'b0;
            while (!back_to_fetch && steps < MAX_PATH) begin
                @(negedge clk);
                sample = ctrl;
                if (sample === fetch_word()) begin
                    back_to_fetch = 1'b1;
                end else begin
                    if (steps < exp_len) begin
                        check_ctrl(sample, expected_word(exp_cls, exp_op, cur_instr, steps),
                                   $sformatf("step %0d", steps));
                    end
                    if (steps == 2 && (exp_cls == CLS_ALU || exp_cls == CLS_BRANCH)) begin
                        check_alu_op(sample.alu.op, exp_op, "execute");
                    end
                    // Decode is taken at the end of IR_LOAD, so an illegal word stays
                    // on instr until the next fetch
                    if (steps == exp_len - 1 && steps >= 2) begin
                        drive_next(t);
                        next_driven = 1'b1;
                    end
                    steps++;
                end
            end
            if (!next_driven) begin
                drive_next(t);
            end
            check_count(steps, exp_len, "path length");
            finish_test(exp_cls.name());
        end

        $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of trace records
    initial begin
        wait (trace_loaded);
        #((num_tests * 6 + 20) * CLK_PERIOD);
        $display("Timeout: run did not end within %0d clock cycles", num_tests * 6 + 20);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== verif/ctrl_trace.txt ====
// Columns, all hex: instruction, test number, class (0 illegal, 1 alu, 2 load,
// 3 store, 4 branch), alu_op. R-type register fields are refilled by the testbench
00000033 01 1 00 // add
40000033 02 1 02 // sub
00001033 03 1 05 // sll
00005033 04 1 06 // srl
00006033 05 1 08 // or
00007033 06 1 07 // and
00004033 07 1 0a // xor
00000033 08 1 00 // add again with other register fields
00510093 09 1 01 // addi x1, x2, 5
fff00193 0a 1 01 // addi x3, x0, -1
123452b7 0b 1 0b // lui x5, 0x12345
00813303 0c 2 00 // ld x6, 8(x2)
00713823 0d 3 00 // sd x7, 16(x2)
00208463 0e 4 02 // beq x1, x2, 8
0020d463 0f 4 02 // bge x1, x2, 8
02000033 10 0 00 // mul
02004033 11 0 00 // div
40005033 12 0 00 // sra
00002013 13 0 00 // slti
00812303 14 0 00 // lw
00712823 15 0 00 // sw
00209463 16 0 00 // bne
0000007f 17 0 00 // unknown opcode
00000000 18 0 00 // all zero word
00813303 19 2 00 // ld right after illegal words
00713823 1a 3 00 // sd
0020d463 1b 4 02 // bge
40000033 1c 1 02 // sub

// ==== vlog.f ====
+incdir+verif
hw/riscv_ctrl_pkg.sv
hw/instr_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_word_gen.sv
hw/riscv_ctrl.sv
verif/tb_riscv_ctrl.sv
